/* logic/scan_out_params.svh */
//////////////////////////////
// Widths, OSD palette and housekeeping defaults for the scan-out path
// Include wherever one of these values is needed
//////////////////////////////

`ifndef SCAN_OUT_PARAMS_SVH
`define SCAN_OUT_PARAMS_SVH

// Bits per color channel
`define PIX_W 8

// Pixels carried per input word
`define PAIR_N 2

// OSD palette, {r, g, b}
`define OSD_BLACK  24'h000000
`define OSD_BLUE   24'h0000ff
`define OSD_YELLOW 24'hffff00
`define OSD_WHITE  24'hffffff

// Force red bit 0 low at the transmitter
`define TX_MASK_R_LSB 1

`define PWM_PERIOD_DEF 1024

// Resync hold counter width
`define LED_HOLD_BITS_DEF 24

`endif

/* logic/scan_out_pkg.sv */
//////////////////////////////
// Pixel, pixel-pair, sync and OSD color types
// Shared by the whole scan-out path
//////////////////////////////

`include "scan_out_params.svh"

package scan_out_pkg;

    typedef struct packed {
        logic [`PIX_W-1:0] r;
        logic [`PIX_W-1:0] g;
        logic [`PIX_W-1:0] b;
    } rgb_t;

    // Active high syncs
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;

    typedef struct packed {
        rgb_t  rgb;
        sync_t sync;
    } pixel_t;

    // Element 0 goes out first
    typedef pixel_t [`PAIR_N-1:0] pixel_pair_t;

    typedef enum logic [1:0] {
        OSD_C_BLACK  = 2'd0,
        OSD_C_BLUE   = 2'd1,
        OSD_C_YELLOW = 2'd2,
        OSD_C_WHITE  = 2'd3
    } osd_color_t;

endpackage

/* logic/pixel_pair_unpacker.sv */
//////////////////////////////
// Takes pixel pairs over valid/ready and sends one pixel per clock
// Emits blank pixels with held syncs when starved
//////////////////////////////

`timescale 1ns/1ps

module pixel_pair_unpacker (
    input  logic                      pclk_out,
    input  logic                      po_reset_n,
    input  logic                      pair_valid_i,
    input  scan_out_pkg::pixel_pair_t pair_i,
    output logic                      pair_ready_o,
    output scan_out_pkg::pixel_t      pix_o
);
    import scan_out_pkg::*;

    pixel_pair_t pair_q;
    logic        full_q;
    logic        phase_q;
    logic        accept;

    // Free when empty, or when the second pixel leaves this cycle
    assign pair_ready_o = ~full_q | phase_q;
    assign accept = pair_valid_i & pair_ready_o;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            full_q <= 1'b0;
            phase_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
            phase_q <= 1'b0;
        end else if (full_q) begin
            full_q <= ~phase_q;
            phase_q <= ~phase_q;
        end
    end

    always_ff @(posedge pclk_out) begin
        if (accept) begin
            pair_q <= pair_i;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix_o <= '0;
        end else if (full_q) begin
            pix_o <= pair_q[phase_q];
        end else begin
            // Blank pixel, hsync and vsync keep their last level
            pix_o.rgb <= '0;
            pix_o.sync.de <= 1'b0;
        end
    end

endmodule

/* logic/osd_overlay.sv */
//////////////////////////////
// OSD overlay stage, one register
// Swaps rgb for a palette color while the OSD is on
//////////////////////////////

`timescale 1ns/1ps

`include "scan_out_params.svh"

module osd_overlay (
    input  logic                     pclk_out,
    input  logic                     po_reset_n,
    input  scan_out_pkg::pixel_t     pix_i,
    input  logic                     osd_enable_i,
    input  scan_out_pkg::osd_color_t osd_color_i,
    output scan_out_pkg::pixel_t     pix_o
);
    import scan_out_pkg::*;

    rgb_t palette_rgb;

    always_comb begin
        unique case (osd_color_i)
            OSD_C_BLACK:  palette_rgb = `OSD_BLACK;
            OSD_C_BLUE:   palette_rgb = `OSD_BLUE;
            OSD_C_YELLOW: palette_rgb = `OSD_YELLOW;
            OSD_C_WHITE:  palette_rgb = `OSD_WHITE;
        endcase
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix_o <= '0;
        end else begin
            pix_o.rgb <= osd_enable_i ? palette_rgb : pix_i.rgb;
            // Syncs ride in the same register to stay aligned
            pix_o.sync <= pix_i.sync;
        end
    end

endmodule

/* logic/tx_output_stage.sv */
//////////////////////////////
// Launch register for the HDMI transmitter
// Masks red bit 0, flags frame start
//////////////////////////////

`timescale 1ns/1ps

`include "scan_out_params.svh"

module tx_output_stage (
    input  logic                 pclk_out,
    input  logic                 po_reset_n,
    input  scan_out_pkg::pixel_t pix_i,
    output scan_out_pkg::rgb_t   tx_rgb_o,
    output scan_out_pkg::sync_t  tx_sync_o,
    output logic                 frame_start_o
);

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            tx_rgb_o <= '0;
            tx_sync_o <= '0;
            frame_start_o <= 1'b0;
        end else begin
            tx_rgb_o <= pix_i.rgb;
            // Board crosstalk on red bit 0
            if (`TX_MASK_R_LSB != 0) begin
                tx_rgb_o.r[0] <= 1'b0;
            end
            tx_sync_o <= pix_i.sync;
            // Registered vsync is the previous one
            frame_start_o <= tx_sync_o.vsync & ~pix_i.sync.vsync;
        end
    end

endmodule

/* logic/pwm_2ch.sv */
//////////////////////////////
// Two PWM channels on one period counter
// Duty in sixteenths of PWM_PERIOD
//////////////////////////////

`timescale 1ns/1ps

`include "scan_out_params.svh"

module pwm_2ch #(
    parameter int PWM_PERIOD = `PWM_PERIOD_DEF
) (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  logic [3:0] ch1_duty_i,
    input  logic [3:0] ch2_duty_i,
    output logic       ch1_pwm_o,
    output logic       ch2_pwm_o
);
    localparam int CNT_W = $clog2(PWM_PERIOD);
    localparam logic [CNT_W-1:0] STEP = CNT_W'(PWM_PERIOD / 16);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PWM_PERIOD - 1);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] ch1_thr;
    logic [CNT_W-1:0] ch2_thr;

    assign ch1_thr = CNT_W'(ch1_duty_i) * STEP;
    assign ch2_thr = CNT_W'(ch2_duty_i) * STEP;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cnt_q <= '0;
            ch1_pwm_o <= 1'b0;
            ch2_pwm_o <= 1'b0;
        end else begin
            if (cnt_q == CNT_LAST) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            ch1_pwm_o <= (cnt_q < ch1_thr);
            ch2_pwm_o <= (cnt_q < ch2_thr);
        end
    end

endmodule

/* logic/led_status.sv */
//////////////////////////////
// Status LEDs and fan drive
// Resync hold timer, standby blink, PWM gating
//////////////////////////////

`timescale 1ns/1ps

`include "scan_out_params.svh"

module led_status #(
    parameter int HOLD_BITS = `LED_HOLD_BITS_DEF
) (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  logic       resync_strobe_i,
    input  logic       sys_poweron_i,
    input  logic       framelock_i,
    input  logic       pll_locked_i,
    input  logic       led_pwm_i,
    input  logic       fan_pwm_i,
    output logic [1:0] led_o,
    output logic       fan_pwm_n_o
);
    logic                 strobe_sync1_q;
    logic                 strobe_sync2_q;
    logic                 strobe_prev_q;
    logic                 strobe_rise;
    logic [HOLD_BITS-1:0] hold_cnt_q;

    // Strobe comes from another domain
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            strobe_sync1_q <= 1'b0;
            strobe_sync2_q <= 1'b0;
            strobe_prev_q <= 1'b0;
        end else begin
            strobe_sync1_q <= resync_strobe_i;
            strobe_sync2_q <= strobe_sync1_q;
            strobe_prev_q <= strobe_sync2_q;
        end
    end

    assign strobe_rise = strobe_sync2_q & ~strobe_prev_q;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hold_cnt_q <= '0;
        end else if (sys_poweron_i) begin
            if (strobe_rise) begin
                hold_cnt_q <= '1;
            end else if (hold_cnt_q != '0) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
            end
        end else if (pll_locked_i) begin
            hold_cnt_q <= '0;
        end else begin
            // Free-running in standby, MSB makes the blink
            hold_cnt_q <= hold_cnt_q - 1'b1;
        end
    end

    assign led_o = {2{led_pwm_i}} & (sys_poweron_i ?
                   {framelock_i, (hold_cnt_q != '0)} :
                   {1'b0, ~hold_cnt_q[HOLD_BITS-1]});

    // Fan driver input is active low
    assign fan_pwm_n_o = ~(sys_poweron_i & fan_pwm_i);

endmodule

/* logic/scan_out_top.sv */
//////////////////////////////
// Scan converter output side on pclk_out
// Video path to the transmitter plus LED and fan housekeeping
//////////////////////////////

`timescale 1ns/1ps

`include "scan_out_params.svh"

module scan_out_top #(
    parameter int PWM_PERIOD = `PWM_PERIOD_DEF,
    parameter int HOLD_BITS  = `LED_HOLD_BITS_DEF
) (
    input  logic                      pclk_out,
    input  logic                      po_reset_n,
    input  logic                      pair_valid_i,
    input  scan_out_pkg::pixel_pair_t pair_i,
    output logic                      pair_ready_o,
    input  logic                      osd_enable_i,
    input  scan_out_pkg::osd_color_t  osd_color_i,
    output scan_out_pkg::rgb_t        tx_rgb_o,
    output scan_out_pkg::sync_t       tx_sync_o,
    output logic                      frame_start_o,
    input  logic                      resync_strobe_i,
    input  logic                      sys_poweron_i,
    input  logic                      framelock_i,
    input  logic                      pll_locked_i,
    input  logic [3:0]                fan_duty_i,
    input  logic [3:0]                led_duty_i,
    output logic [1:0]                led_o,
    output logic                      fan_pwm_n_o
);
    import scan_out_pkg::*;

    pixel_t pix_unpacked;
    pixel_t pix_overlaid;
    logic   fan_pwm;
    logic   led_pwm;

    pixel_pair_unpacker pixel_pair_unpacker_inst (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .pair_valid_i (pair_valid_i),
        .pair_i       (pair_i),
        .pair_ready_o (pair_ready_o),
        .pix_o        (pix_unpacked)
    );

    osd_overlay osd_overlay_inst (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .pix_i        (pix_unpacked),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .pix_o        (pix_overlaid)
    );

    tx_output_stage tx_output_stage_inst (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .pix_i         (pix_overlaid),
        .tx_rgb_o      (tx_rgb_o),
        .tx_sync_o     (tx_sync_o),
        .frame_start_o (frame_start_o)
    );

    // Channel 1 drives the fan, channel 2 dims the LEDs
    pwm_2ch #(
        .PWM_PERIOD (PWM_PERIOD)
    ) pwm_2ch_inst (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .ch1_duty_i (fan_duty_i),
        .ch2_duty_i (led_duty_i),
        .ch1_pwm_o  (fan_pwm),
        .ch2_pwm_o  (led_pwm)
    );

    led_status #(
        .HOLD_BITS (HOLD_BITS)
    ) led_status_inst (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .resync_strobe_i (resync_strobe_i),
        .sys_poweron_i   (sys_poweron_i),
        .framelock_i     (framelock_i),
        .pll_locked_i    (pll_locked_i),
        .led_pwm_i       (led_pwm),
        .fan_pwm_i       (fan_pwm),
        .led_o           (led_o),
        .fan_pwm_n_o     (fan_pwm_n_o)
    );

endmodule

/* tb/scan_out_tb.sv */
//////////////////////////////
// Directed testbench for scan_out_top
// Cycle monitor checks the video path, tasks cover LEDs and fan
//////////////////////////////

`timescale 1ns/1ps

`include "scan_out_params.svh"

module scan_out_tb;
    import scan_out_pkg::*;

    localparam int PWM_PERIOD = 64;
    localparam int HOLD_BITS = 6;
    localparam int STEP = PWM_PERIOD / 16;
    localparam int TIMEOUT_CYCLES = 3000;

    logic        pclk_out = 1'b0;
    logic        po_reset_n;
    logic        pair_valid_i;
    pixel_pair_t pair_i;
    logic        pair_ready_o;
    logic        osd_enable_i;
    osd_color_t  osd_color_i;
    rgb_t        tx_rgb_o;
    sync_t       tx_sync_o;
    logic        frame_start_o;
    logic        resync_strobe_i;
    logic        sys_poweron_i;
    logic        framelock_i;
    logic        pll_locked_i;
    logic [3:0]  fan_duty_i;
    logic [3:0]  led_duty_i;
    logic [1:0]  led_o;
    logic        fan_pwm_n_o;

    // Monitor state
    pixel_t      sched [8];
    logic [7:0]  sched_v = '0;
    int          slot = 0;
    pixel_t      cur;
    pixel_t      exp_d1 = '0;
    pixel_t      exp_d2 = '0;
    logic        fs_d1 = 1'b0;
    logic        fs_d2 = 1'b0;
    logic        acc;
    logic        acc_prev = 1'b0;
    logic        last_hs = 1'b0;
    logic        last_vs = 1'b0;
    logic        tx_vs_model = 1'b0;
    logic        mon_on = 1'b0;
    int          pwm_ph = 0;
    int          cycles = 0;

    scan_out_top #(
        .PWM_PERIOD (PWM_PERIOD),
        .HOLD_BITS  (HOLD_BITS)
    ) scan_out_top_inst (.*);

    always #4 pclk_out = ~pclk_out;

    always @(posedge pclk_out) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            fail_stop();
        end
    end

    // Phase of the PWM period counter
    always @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pwm_ph <= 0;
        end else begin
            pwm_ph <= (pwm_ph + 1) % PWM_PERIOD;
        end
    end

    task automatic fail_stop();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic compare_sync(input string name, input sync_t got, input sync_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic compare_led(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    function automatic rgb_t palette(input osd_color_t c);
        case (c)
            OSD_C_BLACK:  return `OSD_BLACK;
            OSD_C_BLUE:   return `OSD_BLUE;
            OSD_C_YELLOW: return `OSD_YELLOW;
            default:      return `OSD_WHITE;
        endcase
    endfunction

    // Level the registered PWM output shows for this duty
    function automatic logic pwm_level(input logic [3:0] duty);
        return ((pwm_ph + PWM_PERIOD - 1) % PWM_PERIOD) < int'(duty) * STEP;
    endfunction

    function automatic pixel_t rand_pixel(input logic vs);
        pixel_t p;
        p.rgb = 24'($urandom);
        p.sync.hsync = 1'($urandom);
        p.sync.vsync = vs;
        p.sync.de = 1'b1;
        return p;
    endfunction

    function automatic pixel_pair_t make_pair(input logic vs0, input logic vs1);
        pixel_pair_t pr;
        pr[0] = rand_pixel(vs0);
        pr[1] = rand_pixel(vs1);
        return pr;
    endfunction

    task automatic idle(input int n);
        if (n > 0) begin
            repeat (n) @(posedge pclk_out);
            #1;
        end
    endtask

    task automatic send_pair(input pixel_pair_t p);
        pair_i = p;
        pair_valid_i = 1'b1;
        @(negedge pclk_out);
        while (!pair_ready_o) @(negedge pclk_out);
        @(posedge pclk_out);
        #1;
        pair_valid_i = 1'b0;
    endtask

    // Outputs at a negedge belong to the osd input two edges back
    always @(negedge pclk_out) begin
        if (mon_on) begin
            compare_rgb("tx_rgb_o", tx_rgb_o, exp_d2.rgb);
            compare_sync("tx_sync_o", tx_sync_o, exp_d2.sync);
            compare_bit("frame_start_o", frame_start_o, fs_d2);
            // Busy only in the cycle after an accept
            compare_bit("pair_ready_o", pair_ready_o, ~acc_prev);
            acc = pair_valid_i & pair_ready_o;
            if (acc) begin
                sched[(slot + 2) % 8] = pair_i[0];
                sched[(slot + 3) % 8] = pair_i[1];
                sched_v[(slot + 2) % 8] = 1'b1;
                sched_v[(slot + 3) % 8] = 1'b1;
            end
            acc_prev = acc;
            if (sched_v[slot]) begin
                cur = sched[slot];
                sched_v[slot] = 1'b0;
                last_hs = cur.sync.hsync;
                last_vs = cur.sync.vsync;
            end else begin
                cur = '0;
                cur.sync.hsync = last_hs;
                cur.sync.vsync = last_vs;
            end
            if (osd_enable_i) begin
                cur.rgb = palette(osd_color_i);
            end
            cur.rgb.r[0] = 1'b0;
            exp_d2 = exp_d1;
            fs_d2 = fs_d1;
            exp_d1 = cur;
            fs_d1 = tx_vs_model & ~cur.sync.vsync;
            tx_vs_model = cur.sync.vsync;
            slot = (slot + 1) % 8;
        end
    end

    task automatic unpack_test();
        for (int i = 0; i < 20; i++) begin
            send_pair(make_pair(1'($urandom), 1'($urandom)));
        end
        idle(4);
    endtask

    task automatic gap_test();
        for (int i = 0; i < 30; i++) begin
            if ($urandom % 3 != 0) begin
                send_pair(make_pair(1'($urandom), 1'($urandom)));
            end
            idle($urandom % 4);
        end
        idle(4);
    endtask

    task automatic osd_test();
        for (int c = 0; c < 4; c++) begin
            osd_enable_i = 1'b1;
            osd_color_i = osd_color_t'(c);
            repeat (4) send_pair(make_pair(1'($urandom), 1'($urandom)));
            idle(2);
        end
        osd_enable_i = 1'b0;
        repeat (4) send_pair(make_pair(1'($urandom), 1'($urandom)));
        idle(4);
    endtask

    task automatic frame_start_test();
        send_pair(make_pair(1'b1, 1'b1));
        // Falls between the two pixels of one pair
        send_pair(make_pair(1'b1, 1'b0));
        send_pair(make_pair(1'b0, 1'b0));
        send_pair(make_pair(1'b1, 1'b1));
        idle(2);
        send_pair(make_pair(1'b0, 1'b0));
        idle(5);
    endtask

    task automatic pwm_fan_test();
        int fan_low;
        int led_high;
        fan_low = 0;
        led_high = 0;
        sys_poweron_i = 1'b1;
        framelock_i = 1'b1;
        fan_duty_i = 4'd4;
        led_duty_i = 4'd12;
        idle(PWM_PERIOD + 2);
        repeat (PWM_PERIOD) begin
            @(negedge pclk_out);
            if (!fan_pwm_n_o) fan_low++;
            if (led_o[1]) led_high++;
        end
        compare_count("fan_pwm_n_o low cycles", fan_low, 4 * STEP);
        compare_count("led_o[1] high cycles", led_high, 12 * STEP);
        idle(1);
    endtask

    task automatic check_led_when_lit(input logic [1:0] exp);
        @(negedge pclk_out);
        while (!pwm_level(led_duty_i)) @(negedge pclk_out);
        compare_led("led_o", led_o, exp);
        idle(1);
    endtask

    task automatic resync_led_test();
        led_duty_i = 4'd15;
        resync_strobe_i = 1'b1;
        idle(3);
        resync_strobe_i = 1'b0;
        check_led_when_lit({framelock_i, 1'b1});
        idle(70);
        check_led_when_lit({framelock_i, 1'b0});
    endtask

    task automatic standby_test();
        logic [HOLD_BITS-1:0] cnt_exp;
        sys_poweron_i = 1'b0;
        pll_locked_i = 1'b0;
        for (int j = 0; j < 128; j++) begin
            @(posedge pclk_out);
            @(negedge pclk_out);
            cnt_exp = HOLD_BITS'(-(j + 1));
            compare_led("led_o", led_o, {1'b0, ~cnt_exp[HOLD_BITS-1] & pwm_level(led_duty_i)});
            compare_bit("fan_pwm_n_o", fan_pwm_n_o, 1'b1);
        end
        idle(1);
    endtask

    initial begin
        void'($urandom(32'ha7a1b832));
        po_reset_n = 1'b0;
        pair_valid_i = 1'b0;
        pair_i = '0;
        osd_enable_i = 1'b0;
        osd_color_i = OSD_C_BLACK;
        resync_strobe_i = 1'b0;
        sys_poweron_i = 1'b0;
        framelock_i = 1'b0;
        pll_locked_i = 1'b1;
        fan_duty_i = 4'd0;
        led_duty_i = 4'd0;
        repeat (3) @(posedge pclk_out);
        #1;
        po_reset_n = 1'b1;
        mon_on = 1'b1;
        @(negedge pclk_out);
        compare_led("led_o", led_o, 2'b00);
        compare_bit("fan_pwm_n_o", fan_pwm_n_o, 1'b1);
        idle(1);
        unpack_test();
        gap_test();
        osd_test();
        frame_start_test();
        pwm_fan_test();
        resync_led_test();
        standby_test();
        idle(6);
        $display("Everything OK");
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/scan_out_pkg.sv
logic/pixel_pair_unpacker.sv
logic/osd_overlay.sv
logic/tx_output_stage.sv
logic/pwm_2ch.sv
logic/led_status.sv
logic/scan_out_top.sv
tb/scan_out_tb.sv
